/* fma_config.svh */
`ifndef FMA_CONFIG_SVH
`define FMA_CONFIG_SVH

// ----------------------------------------------------------------------
// Binary16 format
// ----------------------------------------------------------------------
`define FMA_EXP_BITS 5
`define FMA_MAN_BITS 10
`define FMA_BIAS     15

// Width of the tag that rides along with each operation
`define FMA_TAG_W    4

// ----------------------------------------------------------------------
// Internal datapath widths
// ----------------------------------------------------------------------
// Precision p, stored mantissa plus hidden bit
`define FMA_PREC     11
// Sum of 3p+4 bits, guard and round included
`define FMA_SUM_W    37
// Signed exponent, wide enough for product and LZC corrections
`define FMA_EXP_W    7
// Shift amounts up to 3p+4
`define FMA_SHAMT_W  6

`endif

/* fma_pkg.sv */
`include "fma_config.svh"

package fma_pkg;

  // Binary16 value in storage layout
  typedef struct packed {
    logic                     sign;
    logic [`FMA_EXP_BITS-1:0] exponent;
    logic [`FMA_MAN_BITS-1:0] mantissa;
  } fp_t;

  // Operand class, exactly one of the first five bits is set
  typedef struct packed {
    logic is_zero;
    logic is_subnormal;
    logic is_normal;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // Exception flags, no divide-by-zero in an FMA
  typedef struct packed {
    logic nv;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // op_mod flips the addend sign on top of these
  typedef enum logic [1:0] {
    FMADD  = 2'd0,
    FNMSUB = 2'd1,
    ADD    = 2'd2,
    MUL    = 2'd3
  } fma_op_e;

  // Everything the normalizer needs, registered after the adder
  typedef struct packed {
    logic                           eff_sub;
    logic signed [`FMA_EXP_W-1:0]   exp_prod;
    logic signed [`FMA_EXP_W-1:0]   exp_diff;
    logic signed [`FMA_EXP_W-1:0]   tent_exp;
    logic        [`FMA_SHAMT_W-1:0] addend_shamt;
    logic                           sticky;
    logic        [`FMA_SUM_W-1:0]   sum;
    logic                           final_sign;
    logic                           is_special;
    fp_t                            special_result;
    status_t                        special_status;
    logic        [`FMA_TAG_W-1:0]   tag;
  } mid_payload_t;

  // Final result as seen at the unit outputs
  typedef struct packed {
    fp_t                     result;
    status_t                 status;
    logic [`FMA_TAG_W-1:0]   tag;
  } out_payload_t;

endpackage

/* fma_pipe_stage.sv */
`timescale 1ns/1ps

module fma_pipe_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     flush_i,
  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // Accept when downstream takes our item or we hold a bubble
  assign ready_o = ready_i | ~valid_o;

  // Valid bit, flush drops whatever is held
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end
  end

  // Payload only moves on a real transfer
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

/* fma_lzc.sv */
`timescale 1ns/1ps

module fma_lzc #(
  parameter int WIDTH = 25
) (
  input  logic [WIDTH-1:0]         in_i,
  output logic [$clog2(WIDTH)-1:0] cnt_o,
  output logic                     empty_o
);

  localparam int CNT_W = $clog2(WIDTH);

  // Scan upward so the highest set bit wins
  always_comb begin
    cnt_o = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (in_i[i]) begin
        cnt_o = CNT_W'(WIDTH - 1 - i);
      end
    end
  end

  assign empty_o = ~|in_i;

endmodule

/* fma_operand_prep.sv */
`timescale 1ns/1ps
`include "fma_config.svh"

module fma_operand_prep
  import fma_pkg::*;
(
  input  fp_t      operand_a_i,
  input  fp_t      operand_b_i,
  input  fp_t      operand_c_i,
  input  fma_op_e  op_i,
  input  logic     op_mod_i,
  output fp_t      a_o,
  output fp_t      b_o,
  output fp_t      c_o,
  output fp_info_t info_a_o,
  output fp_info_t info_b_o,
  output fp_info_t info_c_o
);

  // Biased exponent of +1.0
  localparam logic [`FMA_EXP_BITS-1:0] ONE_EXP = `FMA_BIAS;

  // Decode one operand from its exponent and mantissa fields
  function automatic fp_info_t classify(input fp_t x);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero           = (x.exponent == '0);
    exp_ones           = (x.exponent == '1);
    man_zero           = (x.mantissa == '0);
    info.is_zero       = exp_zero & man_zero;
    info.is_subnormal  = exp_zero & ~man_zero;
    info.is_normal     = ~exp_zero & ~exp_ones;
    info.is_inf        = exp_ones & man_zero;
    info.is_nan        = exp_ones & ~man_zero;
    // Quiet bit clear means signalling
    info.is_signalling = exp_ones & ~man_zero & ~x.mantissa[`FMA_MAN_BITS-1];
    return info;
  endfunction

  always_comb begin
    a_o      = operand_a_i;
    b_o      = operand_b_i;
    c_o      = operand_c_i;
    info_a_o = classify(operand_a_i);
    info_b_o = classify(operand_b_i);
    info_c_o = classify(operand_c_i);

    // op_mod always negates the addend
    c_o.sign = operand_c_i.sign ^ op_mod_i;

    case (op_i)
      // Negate the product through operand a
      FNMSUB: a_o.sign = ~operand_a_i.sign;
      // 1.0 * b + c
      ADD: begin
        a_o      = '{sign: 1'b0, exponent: ONE_EXP, mantissa: '0};
        info_a_o = '{is_normal: 1'b1, default: 1'b0};
      end
      // a * b + (-0), keeps the sign of an exact zero product
      MUL: begin
        c_o      = '{sign: 1'b1, exponent: '0, mantissa: '0};
        info_c_o = '{is_zero: 1'b1, default: 1'b0};
      end
      // FMADD, operands as given
      default: a_o = operand_a_i;
    endcase
  end

endmodule

/* fma_special_case.sv */
`timescale 1ns/1ps
`include "fma_config.svh"

module fma_special_case
  import fma_pkg::*;
(
  input  fp_t      a_i,
  input  fp_t      b_i,
  input  fp_t      c_i,
  input  fp_info_t info_a_i,
  input  fp_info_t info_b_i,
  input  fp_info_t info_c_i,
  output logic     special_o,
  output fp_t      special_result_o,
  output status_t  special_status_o
);

  // Canonical quiet NaN, 7E00h
  localparam fp_t CANON_NAN = '{sign: 1'b0, exponent: '1,
                                mantissa: {1'b1, {(`FMA_MAN_BITS-1){1'b0}}}};

  logic prod_inf;
  logic prod_sign;
  logic eff_sub;
  logic any_nan;
  logic any_snan;

  assign prod_inf  = info_a_i.is_inf | info_b_i.is_inf;
  assign prod_sign = a_i.sign ^ b_i.sign;
  // Product and addend of opposite sign
  assign eff_sub   = prod_sign ^ c_i.sign;
  assign any_nan   = info_a_i.is_nan | info_b_i.is_nan | info_c_i.is_nan;
  assign any_snan  = info_a_i.is_signalling | info_b_i.is_signalling | info_c_i.is_signalling;

  always_comb begin
    special_o        = 1'b0;
    special_result_o = CANON_NAN;
    special_status_o = '0;

    // inf * 0 is invalid whatever the addend, even a quiet NaN
    if ((info_a_i.is_inf && info_b_i.is_zero) || (info_a_i.is_zero && info_b_i.is_inf)) begin
      special_o           = 1'b1;
      special_status_o.nv = 1'b1;
    end else if (any_nan) begin
      // NaN in, canonical NaN out, NV only for sNaN
      special_o           = 1'b1;
      special_status_o.nv = any_snan;
    end else if (prod_inf && info_c_i.is_inf && eff_sub) begin
      // inf - inf
      special_o           = 1'b1;
      special_status_o.nv = 1'b1;
    end else if (prod_inf) begin
      special_o        = 1'b1;
      special_result_o = '{sign: prod_sign, exponent: '1, mantissa: '0};
    end else if (info_c_i.is_inf) begin
      special_o        = 1'b1;
      special_result_o = '{sign: c_i.sign, exponent: '1, mantissa: '0};
    end
  end

endmodule

/* fma_datapath.sv */
`timescale 1ns/1ps
`include "fma_config.svh"

module fma_datapath
  import fma_pkg::*;
(
  input  fp_t                            a_i,
  input  fp_t                            b_i,
  input  fp_t                            c_i,
  input  fp_info_t                       info_a_i,
  input  fp_info_t                       info_b_i,
  input  fp_info_t                       info_c_i,
  output logic                           eff_sub_o,
  output logic signed [`FMA_EXP_W-1:0]   exp_prod_o,
  output logic signed [`FMA_EXP_W-1:0]   exp_diff_o,
  output logic signed [`FMA_EXP_W-1:0]   tent_exp_o,
  output logic        [`FMA_SHAMT_W-1:0] addend_shamt_o,
  output logic                           sticky_o,
  output logic        [`FMA_SUM_W-1:0]   sum_o,
  output logic                           final_sign_o
);

  localparam int PREC    = `FMA_PREC;
  localparam int SUM_W   = `FMA_SUM_W;
  localparam int EXP_W   = `FMA_EXP_W;
  localparam int SHAMT_W = `FMA_SHAMT_W;
  localparam int BIAS    = `FMA_BIAS;

  // ----------------------------------------------------------------------
  // Exponent path
  // ----------------------------------------------------------------------
  logic signed [EXP_W-1:0] exp_a;
  logic signed [EXP_W-1:0] exp_b;
  logic signed [EXP_W-1:0] exp_c;
  logic                    tent_sign;

  // Subnormals behave as exponent 1 without hidden bit
  assign exp_a = EXP_W'(a_i.exponent) + EXP_W'(info_a_i.is_subnormal);
  assign exp_b = EXP_W'(b_i.exponent) + EXP_W'(info_b_i.is_subnormal);
  assign exp_c = EXP_W'(c_i.exponent) + EXP_W'(!info_c_i.is_normal);

  // Zero product gets the smallest exponent so the addend anchors
  assign exp_prod_o = (info_a_i.is_zero || info_b_i.is_zero) ? EXP_W'(2 - BIAS)
                                                             : EXP_W'(exp_a + exp_b - BIAS);
  assign exp_diff_o = exp_c - exp_prod_o;
  assign tent_exp_o = (exp_diff_o > 0) ? exp_c : exp_prod_o;

  assign eff_sub_o  = a_i.sign ^ b_i.sign ^ c_i.sign;
  // Product sign is the first guess for the result sign
  assign tent_sign  = a_i.sign ^ b_i.sign;

  // Addend right shift, saturated at both ends
  always_comb begin
    if (exp_diff_o <= -(2 * PREC + 1)) begin
      // Addend lands entirely in the sticky bit
      addend_shamt_o = SHAMT_W'(3 * PREC + 4);
    end else if (exp_diff_o <= PREC + 2) begin
      addend_shamt_o = SHAMT_W'(PREC + 3 - exp_diff_o);
    end else begin
      // Addend anchored, product only affects the low bits
      addend_shamt_o = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Mantissa path
  // ----------------------------------------------------------------------
  logic [PREC-1:0]       man_a;
  logic [PREC-1:0]       man_b;
  logic [PREC-1:0]       man_c;
  logic [2*PREC-1:0]     product;
  logic [SUM_W-1:0]      product_shifted;
  logic [SUM_W+PREC-1:0] addend_wide;
  logic [SUM_W-1:0]      addend_aligned;
  logic [PREC-1:0]       addend_sticky;
  logic [SUM_W-1:0]      addend_inv;
  logic                  inject_carry;
  logic [SUM_W:0]        sum_raw;
  logic [SUM_W:0]        sum_neg;

  // Hidden bit from the class
  assign man_a = {info_a_i.is_normal, a_i.mantissa};
  assign man_b = {info_b_i.is_normal, b_i.mantissa};
  assign man_c = {info_c_i.is_normal, c_i.mantissa};

  assign product = man_a * man_b;

  // Layout is p+2 zeros, 2p product bits, then round and sticky slots
  assign product_shifted = {{(PREC + 2){1'b0}}, product, 2'b00};

  // Up to p bits fall off the bottom into the sticky bit
  assign addend_wide = {man_c, {SUM_W{1'b0}}} >> addend_shamt_o;
  assign {addend_aligned, addend_sticky} = addend_wide;
  assign sticky_o = |addend_sticky;

  // Two's complement of the addend, carry-in dropped if bits were lost
  assign addend_inv   = eff_sub_o ? ~addend_aligned : addend_aligned;
  assign inject_carry = eff_sub_o & ~sticky_o;

  // ----------------------------------------------------------------------
  // Adder and sign fix
  // ----------------------------------------------------------------------
  assign sum_raw = product_shifted + addend_inv + inject_carry;
  assign sum_neg = -sum_raw;

  // No carry out on a subtraction means the addend won
  assign sum_o        = (eff_sub_o && !sum_raw[SUM_W]) ? sum_neg[SUM_W-1:0]
                                                       : sum_raw[SUM_W-1:0];
  assign final_sign_o = eff_sub_o ? (sum_raw[SUM_W] == tent_sign) : tent_sign;

endmodule

/* fma_normalize_round.sv */
`timescale 1ns/1ps
`include "fma_config.svh"

module fma_normalize_round
  import fma_pkg::*;
(
  input  mid_payload_t mid_i,
  output out_payload_t out_o
);

  localparam int PREC     = `FMA_PREC;
  localparam int SUM_W    = `FMA_SUM_W;
  localparam int EXP_W    = `FMA_EXP_W;
  localparam int SHAMT_W  = `FMA_SHAMT_W;
  localparam int EXP_BITS = `FMA_EXP_BITS;
  localparam int MAN_BITS = `FMA_MAN_BITS;
  localparam int ABS_W    = EXP_BITS + MAN_BITS;
  // Only the low 2p+3 sum bits can hold a cancellation
  localparam int LOW_W    = 2 * PREC + 3;
  localparam int LZC_W    = $clog2(LOW_W);

  // ----------------------------------------------------------------------
  // Normalization
  // ----------------------------------------------------------------------
  logic signed [EXP_W-1:0] exp_prod;
  logic signed [EXP_W-1:0] exp_diff;
  logic [LZC_W-1:0]        lz_cnt;
  logic signed [LZC_W:0]   lz_cnt_sgn;
  logic                    lz_empty;
  logic [SHAMT_W-1:0]      norm_shamt;
  logic signed [EXP_W-1:0] norm_exp;
  logic [SUM_W:0]          sum_shifted;
  logic [PREC:0]           final_man;
  logic [LOW_W-1:0]        sticky_bits;
  logic signed [EXP_W-1:0] final_exp;
  logic                    sticky_norm;

  assign exp_prod = mid_i.exp_prod;
  assign exp_diff = mid_i.exp_diff;

  fma_lzc #(
    .WIDTH (LOW_W)
  ) u_lzc (
    .in_i    (mid_i.sum[LOW_W-1:0]),
    .cnt_o   (lz_cnt),
    .empty_o (lz_empty)
  );

  assign lz_cnt_sgn = $signed({1'b0, lz_cnt});

  always_comb begin
    // Product anchored or possible cancellation
    if ((exp_diff <= 0) || (mid_i.eff_sub && (exp_diff <= 2))) begin
      if ((exp_prod - lz_cnt_sgn + 1 >= 0) && !lz_empty) begin
        // Undo the product offset and strip the leading zeros
        norm_shamt = SHAMT_W'(PREC + 2 + lz_cnt);
        norm_exp   = EXP_W'(exp_prod - lz_cnt_sgn + 1);
      end else begin
        // Subnormal result, stop the shift at the minimum exponent
        norm_shamt = SHAMT_W'(PREC + 2 + exp_prod);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, simply reverse the alignment
      norm_shamt = mid_i.addend_shamt;
      norm_exp   = mid_i.tent_exp;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum} << norm_shamt;

  // One-bit fixup, leading one may sit one place either side
  always_comb begin
    {final_man, sticky_bits} = sum_shifted[SUM_W-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[SUM_W]) begin
      {final_man, sticky_bits} = sum_shifted[SUM_W:1];
      final_exp                = EXP_W'(norm_exp + 1);
    end else if (!sum_shifted[SUM_W-1] && (norm_exp > 1)) begin
      {final_man, sticky_bits} = {sum_shifted[SUM_W-2:0], 1'b0};
      final_exp                = EXP_W'(norm_exp - 1);
    end else if (!sum_shifted[SUM_W-1]) begin
      // Still no hidden bit, so subnormal
      final_exp = '0;
    end
  end

  assign sticky_norm = (|sticky_bits) | mid_i.sticky;

  // ----------------------------------------------------------------------
  // Rounding, round to nearest even only
  // ----------------------------------------------------------------------
  logic                of_before;
  logic [EXP_BITS-1:0] pre_exp;
  logic [MAN_BITS-1:0] pre_man;
  logic [ABS_W-1:0]    pre_abs;
  logic [1:0]          round_sticky;
  logic                round_up;
  logic [ABS_W-1:0]    rounded_abs;
  logic                exact_zero;
  logic                rounded_sign;
  logic                of_after;
  logic                uf_after;
  logic                of_any;
  logic                inexact;
  fp_t                 regular_result;
  status_t             regular_status;

  // All-ones exponent is already infinity
  assign of_before = final_exp >= (2**EXP_BITS - 1);

  // On overflow start from the largest finite value and force a round-up
  assign pre_exp      = of_before ? EXP_BITS'(2**EXP_BITS - 2) : final_exp[EXP_BITS-1:0];
  assign pre_man      = of_before ? '1 : final_man[MAN_BITS:1];
  assign pre_abs      = {pre_exp, pre_man};
  assign round_sticky = of_before ? 2'b11 : {final_man[0], sticky_norm};

  // Ties go to the even neighbour
  assign round_up    = round_sticky[1] & (round_sticky[0] | pre_man[0]);
  assign rounded_abs = pre_abs + ABS_W'(round_up);

  // x - x gives +0 under RNE
  assign exact_zero   = (pre_abs == '0) && (round_sticky == 2'b00);
  assign rounded_sign = (exact_zero && mid_i.eff_sub) ? 1'b0 : mid_i.final_sign;

  assign of_after = (rounded_abs[ABS_W-1:MAN_BITS] == '1);
  assign uf_after = (rounded_abs[ABS_W-1:MAN_BITS] == '0);

  assign of_any  = of_before | of_after;
  assign inexact = (|round_sticky) | of_any;

  assign regular_result = {rounded_sign, rounded_abs};
  // Underflow only for tiny results that also lost bits
  assign regular_status = '{nv: 1'b0, of: of_any, uf: uf_after & inexact, nx: inexact};

  // ----------------------------------------------------------------------
  // Result selection
  // ----------------------------------------------------------------------
  assign out_o.result = mid_i.is_special ? mid_i.special_result : regular_result;
  assign out_o.status = mid_i.is_special ? mid_i.special_status : regular_status;
  assign out_o.tag    = mid_i.tag;

endmodule

/* fma_unit.sv */
`timescale 1ns/1ps
`include "fma_config.svh"

module fma_unit
  import fma_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // Input handshake and operands
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  fp_t                   operand_a_i,
  input  fp_t                   operand_b_i,
  input  fp_t                   operand_c_i,
  input  fma_op_e               op_i,
  input  logic                  op_mod_i,
  input  logic [`FMA_TAG_W-1:0] tag_i,
  input  logic                  flush_i,
  // Result and output handshake
  output fp_t                   result_o,
  output status_t               status_o,
  output logic [`FMA_TAG_W-1:0] tag_o,
  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output logic                  busy_o
);

  // ----------------------------------------------------------------------
  // Operand prep, special cases and adder
  // ----------------------------------------------------------------------
  fp_t                           a, b, c;
  fp_info_t                      info_a, info_b, info_c;
  logic                          special;
  fp_t                           special_result;
  status_t                       special_status;
  logic                          eff_sub;
  logic signed [`FMA_EXP_W-1:0]  exp_prod, exp_diff, tent_exp;
  logic        [`FMA_SHAMT_W-1:0] addend_shamt;
  logic                          sticky;
  logic        [`FMA_SUM_W-1:0]  sum;
  logic                          final_sign;

  fma_operand_prep u_operand_prep (
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .a_o         (a),
    .b_o         (b),
    .c_o         (c),
    .info_a_o    (info_a),
    .info_b_o    (info_b),
    .info_c_o    (info_c)
  );

  fma_special_case u_special_case (
    .a_i              (a),
    .b_i              (b),
    .c_i              (c),
    .info_a_i         (info_a),
    .info_b_i         (info_b),
    .info_c_i         (info_c),
    .special_o        (special),
    .special_result_o (special_result),
    .special_status_o (special_status)
  );

  fma_datapath u_datapath (
    .a_i            (a),
    .b_i            (b),
    .c_i            (c),
    .info_a_i       (info_a),
    .info_b_i       (info_b),
    .info_c_i       (info_c),
    .eff_sub_o      (eff_sub),
    .exp_prod_o     (exp_prod),
    .exp_diff_o     (exp_diff),
    .tent_exp_o     (tent_exp),
    .addend_shamt_o (addend_shamt),
    .sticky_o       (sticky),
    .sum_o          (sum),
    .final_sign_o   (final_sign)
  );

  // ----------------------------------------------------------------------
  // Stage registers and normalization
  // ----------------------------------------------------------------------
  mid_payload_t mid_d, mid_q;
  out_payload_t out_d, out_q;
  logic         mid_valid;
  logic         mid_ready;

  assign mid_d = '{eff_sub:        eff_sub,
                   exp_prod:       exp_prod,
                   exp_diff:       exp_diff,
                   tent_exp:       tent_exp,
                   addend_shamt:   addend_shamt,
                   sticky:         sticky,
                   sum:            sum,
                   final_sign:     final_sign,
                   is_special:     special,
                   special_result: special_result,
                   special_status: special_status,
                   tag:            tag_i};

  fma_pipe_stage #(
    .payload_t (mid_payload_t)
  ) mid_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (mid_d),
    .valid_o (mid_valid),
    .ready_i (mid_ready),
    .data_o  (mid_q)
  );

  fma_normalize_round u_normalize_round (
    .mid_i (mid_q),
    .out_o (out_d)
  );

  // Ready flows back from the output port
  fma_pipe_stage #(
    .payload_t (out_payload_t)
  ) out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .valid_i (mid_valid),
    .ready_o (mid_ready),
    .data_i  (out_d),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_q)
  );

  assign result_o = out_q.result;
  assign status_o = out_q.status;
  assign tag_o    = out_q.tag;
  // Anything held in either stage
  assign busy_o   = mid_valid | out_valid_o;

endmodule

/* tb_fma_unit.sv */
`timescale 1ns/1ps
`include "fma_config.svh"

// Free-running clock for the testbench
module fma_tb_clock #(
  parameter int HALF_PERIOD_NS = 50
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

endmodule

module tb_fma_unit
  import fma_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;
  localparam int STREAM_OPS     = 40;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  fp_t                   operand_a_i;
  fp_t                   operand_b_i;
  fp_t                   operand_c_i;
  fma_op_e               op_i;
  logic                  op_mod_i;
  logic [`FMA_TAG_W-1:0] tag_i;
  logic                  flush_i;
  fp_t                   result_o;
  status_t               status_o;
  logic [`FMA_TAG_W-1:0] tag_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  busy_o;

  fma_tb_clock #(
    .HALF_PERIOD_NS (50)
  ) u_clock (
    .clk_o (clk_i)
  );

  fma_unit UUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .tag_i       (tag_i),
    .flush_i     (flush_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .busy_o      (busy_o)
  );

  // ----------------------------------------------------------------------
  // Vector table, scoreboard and run state
  // ----------------------------------------------------------------------
  string       vec_name[$];
  logic [15:0] vec_a[$];
  logic [15:0] vec_b[$];
  logic [15:0] vec_c[$];
  fma_op_e     vec_op[$];
  logic        vec_mod[$];
  logic [15:0] vec_res[$];
  logic [3:0]  vec_st[$];

  // Expected items in issue order
  int          exp_idx_q[$];
  logic [3:0]  exp_tag_q[$];

  int unsigned lcg_state = 7546;
  int          cycle_cnt = 0;
  int          accept_cycle = 0;
  int          out_cycle = 0;
  logic        last_in_fire = 1'b0;
  logic        last_out_fire = 1'b0;

  task automatic add_vector(input string name, input logic [15:0] a, input logic [15:0] b,
                            input logic [15:0] c, input fma_op_e op, input logic op_mod,
                            input logic [15:0] res, input logic [3:0] st);
    vec_name.push_back(name);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_c.push_back(c);
    vec_op.push_back(op);
    vec_mod.push_back(op_mod);
    vec_res.push_back(res);
    vec_st.push_back(st);
  endtask

  // Status nibble is NV, OF, UF, NX from the top
  task automatic load_vectors();
    add_vector("fmadd 2*3+1",      16'h4000, 16'h4200, 16'h3C00, FMADD,  1'b0, 16'h4700, 4'h0);
    add_vector("fmsub 2*3-1",      16'h4000, 16'h4200, 16'h3C00, FMADD,  1'b1, 16'h4500, 4'h0);
    add_vector("fnmsub -(2*3)+1",  16'h4000, 16'h4200, 16'h3C00, FNMSUB, 1'b0, 16'hC500, 4'h0);
    add_vector("fnmadd -(2*3)-1",  16'h4000, 16'h4200, 16'h3C00, FNMSUB, 1'b1, 16'hC700, 4'h0);
    add_vector("add 1+2",          16'h0000, 16'h3C00, 16'h4000, ADD,    1'b0, 16'h4200, 4'h0);
    add_vector("sub 3-3",          16'h0000, 16'h4200, 16'h4200, ADD,    1'b1, 16'h0000, 4'h0);
    // 2049 and 2051 sit halfway between neighbours
    add_vector("add tie down",     16'h0000, 16'h6800, 16'h3C00, ADD,    1'b0, 16'h6800, 4'h1);
    add_vector("add tie up",       16'h0000, 16'h6801, 16'h3C00, ADD,    1'b0, 16'h6802, 4'h1);
    add_vector("mul 3*5",          16'h4200, 16'h4500, 16'h0000, MUL,    1'b0, 16'h4B80, 4'h0);
    add_vector("mul 0*-3",         16'h0000, 16'hC200, 16'h0000, MUL,    1'b0, 16'h8000, 4'h0);
    add_vector("inf*0+qnan",       16'h7C00, 16'h0000, 16'h7E00, FMADD,  1'b0, 16'h7E00, 4'h8);
    add_vector("snan operand",     16'h7D00, 16'h3C00, 16'h0000, FMADD,  1'b0, 16'h7E00, 4'h8);
    add_vector("qnan operand",     16'h7E00, 16'h3C00, 16'h3C00, FMADD,  1'b0, 16'h7E00, 4'h0);
    add_vector("inf-inf",          16'h7C00, 16'h3C00, 16'h7C00, FMADD,  1'b1, 16'h7E00, 4'h8);
    add_vector("inf*2+1",          16'h7C00, 16'h4000, 16'h3C00, FMADD,  1'b0, 16'h7C00, 4'h0);
    add_vector("mul 60000*60000",  16'h7B53, 16'h7B53, 16'h0000, MUL,    1'b0, 16'h7C00, 4'h5);
    // 1.5 ulp of the smallest subnormal, tie to 2 ulp
    add_vector("mul subnormal",    16'h0003, 16'h3800, 16'h0000, MUL,    1'b0, 16'h0002, 4'h3);
  endtask

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic pick_ready(input logic random_ready);
    int unsigned r;
    r = lcg_next();
    return random_ready ? r[16] : 1'b1;
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
      abort_run();
    end
  endtask

  // One clock cycle: drive on the falling edge, then observe the handshakes
  // that the next rising edge will complete
  task automatic step(input logic valid, input int idx, input logic [3:0] tag,
                      input logic ready);
    int held;
    int e_idx;
    logic [3:0] e_tag;
    @(negedge clk_i);
    in_valid_i = valid;
    if (valid) begin
      operand_a_i = vec_a[idx];
      operand_b_i = vec_b[idx];
      operand_c_i = vec_c[idx];
      op_i        = vec_op[idx];
      op_mod_i    = vec_mod[idx];
      tag_i       = tag;
    end
    out_ready_i = ready;
    #1;
    held = exp_idx_q.size();
    // Input stalls only with both stages full and the output blocked
    check_value("in_ready_o", !(held == 2 && !ready), in_ready_o);
    check_value("busy_o", held != 0, busy_o);
    last_in_fire  = in_valid_i && in_ready_o;
    last_out_fire = out_valid_o && out_ready_i;
    if (last_out_fire) begin
      out_cycle = cycle_cnt;
      if (held == 0) begin
        $display("output handshake with no operation in flight, tag %0h", tag_o);
        abort_run();
      end else begin
        e_idx = exp_idx_q.pop_front();
        e_tag = exp_tag_q.pop_front();
        check_value({vec_name[e_idx], " result"}, vec_res[e_idx], result_o);
        check_value({vec_name[e_idx], " status"}, vec_st[e_idx], status_o);
        check_value({vec_name[e_idx], " tag"}, e_tag, tag_o);
      end
    end
    if (last_in_fire) begin
      accept_cycle = cycle_cnt;
      exp_idx_q.push_back(idx);
      exp_tag_q.push_back(tag);
    end
    cycle_cnt++;
  endtask

  // Hold one operation on the input until it is taken
  task automatic send_op(input int idx, input logic [3:0] tag, input logic random_ready);
    int tries;
    tries = 0;
    last_in_fire = 1'b0;
    while (!last_in_fire) begin
      if (tries == TIMEOUT_CYCLES) begin
        $display("timeout, operation %s was never accepted", vec_name[idx]);
        abort_run();
      end else begin
        step(1'b1, idx, tag, pick_ready(random_ready));
        tries++;
      end
    end
  endtask

  task automatic drain(input logic random_ready);
    int tries;
    tries = 0;
    while (exp_idx_q.size() != 0) begin
      if (tries == TIMEOUT_CYCLES) begin
        $display("timeout, %0d results never came out", exp_idx_q.size());
        abort_run();
      end else begin
        step(1'b0, 0, 4'h0, pick_ready(random_ready));
        tries++;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    int tries;
    int idx;
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    op_i        = FMADD;
    op_mod_i    = 1'b0;
    tag_i       = '0;
    flush_i     = 1'b0;
    out_ready_i = 1'b1;
    load_vectors();

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_value("reset out_valid_o", 1'b0, out_valid_o);
    check_value("reset busy_o", 1'b0, busy_o);
    check_value("reset in_ready_o", 1'b1, in_ready_o);

    // Directed vectors back to back
    for (int i = 0; i < vec_name.size(); i++) begin
      send_op(i, 4'(i), 1'b0);
    end
    drain(1'b0);

    // Random back-pressure, order and tags checked by the scoreboard
    for (int i = 0; i < STREAM_OPS; i++) begin
      idx = int'((lcg_next() >> 8) % vec_name.size());
      send_op(idx, 4'(i), 1'b1);
    end
    drain(1'b1);

    // Latency with the output always ready
    send_op(0, 4'h5, 1'b0);
    tries = 0;
    last_out_fire = 1'b0;
    while (!last_out_fire) begin
      if (tries == TIMEOUT_CYCLES) begin
        $display("timeout, single operation produced no result");
        abort_run();
      end else begin
        step(1'b0, 0, 4'h0, 1'b1);
        tries++;
      end
    end
    check_value("latency", 2, out_cycle - accept_cycle);

    // Fill both stages, stall a third operation, then flush
    send_op(1, 4'h1, 1'b0);
    out_ready_i = 1'b0;
    step(1'b1, 2, 4'h2, 1'b0);
    step(1'b1, 3, 4'h3, 1'b0);
    step(1'b1, 4, 4'h4, 1'b0);
    drain(1'b0);
    step(1'b1, 5, 4'h6, 1'b0);
    step(1'b1, 6, 4'h7, 1'b0);
    step(1'b1, 7, 4'h8, 1'b0);
    @(negedge clk_i);
    in_valid_i = 1'b0;
    flush_i    = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    #1;
    check_value("flush out_valid_o", 1'b0, out_valid_o);
    check_value("flush busy_o", 1'b0, busy_o);
    exp_idx_q.delete();
    exp_tag_q.delete();
    // Nothing stale may appear afterwards
    repeat (5) step(1'b0, 0, 4'h0, 1'b1);

    $display("All checks passed");
    $finish;
  end

endmodule

/* fma_unit.f */
+incdir+.
fma_pkg.sv
fma_pipe_stage.sv
fma_lzc.sv
fma_operand_prep.sv
fma_special_case.sv
fma_datapath.sv
fma_normalize_round.sv
fma_unit.sv
tb_fma_unit.sv

/* run.sh */
#!/bin/sh
# Build and run the FMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_fma_unit \
  -f fma_unit.f -o sim_fma_unit

output=$(./obj_dir/sim_fma_unit 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
  exit 0
fi
exit 1
